// File: sources.f
src/vc_mem_pkg.sv
src/mem_issue.sv
src/load_return.sv
src/vc_mem_stage.sv
verif/vc_mem_assertions.sv
verif/tb_vc_mem_stage.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the vc_mem_stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_vc_mem_stage \
   -f sources.f

# Keep running past assertion errors so the testbench prints its verdict
./obj_dir/Vtb_vc_mem_stage +verilator+error+limit+1000 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
grep -q ">>> PASS" sim.log

// File: verif/tb_vc_mem_stage.sv
`timescale 1ns/1ps

module tb_vc_mem_stage;
   import vc_mem_pkg::*;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 16;
   localparam int N_WORD       = 24;
   localparam int N_MERGE      = 16;
   // Passes over the 12 size, offset and sign combinations
   localparam int N_OFFS       = 2;
   localparam int N_RAND       = 60;
   localparam int N_HOLD       = 40;
   localparam int N_RESV       = 3;
   localparam int TOTAL_REQS   = 2 * N_WORD + 2 * N_MERGE + 12 * N_OFFS + N_RAND + N_HOLD
                                 + N_RESV;
   localparam int TIMEOUT_CYCLES = TOTAL_REQS * 40 + RESET_CYCLES;

   // Expected memory command, in issue order
   typedef struct packed {
      logic       is_load;
      size_t      size;
      logic       uns;
      word_t      addr;
      byte_mask_t mask;
      word_t      data;
      reg_addr_t  rd;
   } exp_op_s;

   typedef struct packed {
      reg_addr_t rd;
      word_t     data;
   } exp_wb_s;

   logic      clk = 1'b0;
   logic      reset;
   mem_req_s  req_i;
   logic      hold_i;
   mem_resp_s from_mem_i;
   logic      reservation_i;
   mem_cmd_s  to_mem_o;
   logic      stall_o;
   logic      reserve_o;
   wb_s       wb_o;

   int        seed = 32'h7203_a716;
   // Memory model written by DUT commands, shadow written by the store rule
   word_t     mem [16];
   word_t     ref_mem [16];
   mem_req_s  send_q [$];
   exp_op_s   op_q [$];
   exp_wb_s   wb_q [$];
   word_t     reply_q [$];
   int        reply_due_q [$];
   exp_wb_s   wb_want;
   int        cyc = 0;
   int        yumi_delay = 0;
   int        errors = 0;
   int        checks = 0;
   int        req_count = 0;
   int        test_num = 0;
   bit        hold_mode = 1'b0;
   logic      resv_level = 1'b0;
   // Which kind of LR sits in the execute stage
   bit        exe_plain_lr = 1'b0;
   bit        exe_acq_lr = 1'b0;
   bit        reserve_seen = 1'b0;

   vc_mem_stage u_vc_mem_stage
   (
      .clk           (clk),
      .reset         (reset),
      .req_i         (req_i),
      .hold_i        (hold_i),
      .from_mem_i    (from_mem_i),
      .reservation_i (reservation_i),
      .to_mem_o      (to_mem_o),
      .stall_o       (stall_o),
      .reserve_o     (reserve_o),
      .wb_o          (wb_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////
   // Reporting
   ////////////////////////////////////////

   task automatic value_error(string name, word_t want, word_t got);
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, want, got);
      errors++;
   endtask

   task automatic plain_error(string what);
      $display("error at %0t: %s", $time, what);
      errors++;
   endtask

   ////////////////////////////////////////
   // Reference rules
   ////////////////////////////////////////

   // Byte enables of a store
   function automatic byte_mask_t expected_mask(size_t size, logic [1:0] lo);
      byte_mask_t m;
      m = 4'b0000;
      if (size == SIZE_BYTE)
      begin
         m[lo] = 1'b1;
      end
      else if (size == SIZE_HALF)
      begin
         m = lo[1] ? 4'b1100 : 4'b0011;
      end
      else
      begin
         m = 4'b1111;
      end
      return m;
   endfunction

   function automatic word_t lane_bits(byte_mask_t mask);
      word_t bits;
      for (int b = 0; b < 4; b++)
      begin
         bits[8*b +: 8] = {8{mask[b]}};
      end
      return bits;
   endfunction

   // Store data replicated, then cut to the enabled lanes
   function automatic word_t expected_lane(size_t size, logic [1:0] lo, word_t val);
      if (size == SIZE_BYTE)
      begin
         return {4{val[7:0]}} & lane_bits(expected_mask(size, lo));
      end
      if (size == SIZE_HALF)
      begin
         return {2{val[15:0]}} & lane_bits(expected_mask(size, lo));
      end
      return val;
   endfunction

   // Expected load result from the stored word
   function automatic word_t expected_load(word_t word, logic [1:0] lo, size_t size,
                                           logic uns);
      word_t sh;
      sh = word >> (8 * lo);
      if (size == SIZE_BYTE)
      begin
         return uns ? {24'b0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
      end
      if (size == SIZE_HALF)
      begin
         return uns ? {16'b0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
      end
      return word;
   endfunction

   function automatic word_t merge_word(word_t old, byte_mask_t mask, word_t data);
      word_t w;
      w = old;
      for (int b = 0; b < 4; b++)
      begin
         if (mask[b])
         begin
            w[8*b +: 8] = data[8*b +: 8];
         end
      end
      return w;
   endfunction

   // Aligned address inside the 64-byte model
   function automatic word_t rand_addr(size_t size);
      word_t a;
      a = word_t'($random(seed)) & 32'h0000_003f;
      if (size == SIZE_HALF)
      begin
         a[0] = 1'b0;
      end
      else if (size == SIZE_WORD)
      begin
         a[1:0] = 2'b00;
      end
      return a;
   endfunction

   ////////////////////////////////////////
   // Stimulus and memory model
   ////////////////////////////////////////

   task automatic queue_req(logic is_store, size_t size, logic uns, word_t addr, word_t data,
                            logic lr, logic acq);
      mem_req_s req;
      exp_op_s  op;
      req = '0;
      req.valid = 1'b1;
      req.is_load = ~is_store;
      req.is_store = is_store;
      req.size = size;
      req.load_unsigned = uns;
      req.is_lr = lr;
      req.lr_acquire = acq;
      req.store_val = data;
      req.rd = reg_addr_t'($random(seed));
      // LR ignores the offset, so give it noise
      if (lr)
      begin
         req.base = addr;
         req.offset = $random(seed);
      end
      else
      begin
         req.base = $random(seed);
         req.offset = addr - req.base;
      end
      op.is_load = ~is_store;
      op.size = size;
      op.uns = uns;
      op.addr = addr;
      op.mask = expected_mask(size, addr[1:0]);
      op.data = expected_lane(size, addr[1:0], data);
      op.rd = req.rd;
      send_q.push_back(req);
      op_q.push_back(op);
      req_count++;
   endtask

   // Memory accepted a command, check it against the oldest request
   task automatic accept_cmd();
      exp_op_s op;
      exp_wb_s wb;
      checks++;
      if (op_q.size() == 0)
      begin
         plain_error("memory command with no request behind it");
         return;
      end
      op = op_q.pop_front();
      if (to_mem_o.addr !== op.addr)
      begin
         value_error("to_mem_o.addr", op.addr, to_mem_o.addr);
      end
      if (to_mem_o.wen !== ~op.is_load)
      begin
         value_error("to_mem_o.wen", word_t'(~op.is_load), word_t'(to_mem_o.wen));
      end
      if (!op.is_load)
      begin
         if (to_mem_o.mask !== op.mask)
         begin
            value_error("to_mem_o.mask", word_t'(op.mask), word_t'(to_mem_o.mask));
         end
         if (to_mem_o.write_data !== op.data)
         begin
            value_error("to_mem_o.write_data", op.data, to_mem_o.write_data);
         end
         mem[to_mem_o.addr[5:2]] = merge_word(mem[to_mem_o.addr[5:2]], to_mem_o.mask,
                                              to_mem_o.write_data);
         ref_mem[op.addr[5:2]] = merge_word(ref_mem[op.addr[5:2]], op.mask, op.data);
      end
      else
      begin
         wb.rd = op.rd;
         wb.data = expected_load(ref_mem[op.addr[5:2]], op.addr[1:0], op.size, op.uns);
         wb_q.push_back(wb);
      end
      // Reply 1 to 3 cycles on, behind any reply still queued
      reply_q.push_back(mem[to_mem_o.addr[5:2]]);
      reply_due_q.push_back(cyc + 1 + $unsigned($random(seed)) % 3);
      yumi_delay = $unsigned($random(seed)) % 4;
   endtask

   // Drive on the falling edge and look just before the rising one
   task automatic cycle();
      @(negedge clk);
      cyc++;
      from_mem_i.yumi = (yumi_delay == 0);
      if (yumi_delay > 0)
      begin
         yumi_delay--;
      end
      if (reply_q.size() > 0 && reply_due_q[0] <= cyc)
      begin
         from_mem_i.valid = 1'b1;
         from_mem_i.read_data = reply_q[0];
      end
      else
      begin
         from_mem_i.valid = 1'b0;
         from_mem_i.read_data = '0;
      end
      hold_i = hold_mode && (($random(seed) & 3) == 0);
      reservation_i = resv_level;
      req_i = (send_q.size() > 0) ? send_q[0] : '0;
      #1;
      if (to_mem_o.valid && from_mem_i.yumi)
      begin
         accept_cmd();
      end
      if (to_mem_o.yumi)
      begin
         if (!from_mem_i.valid)
         begin
            plain_error("reply acknowledged while none was offered");
         end
         else
         begin
            void'(reply_q.pop_front());
            void'(reply_due_q.pop_front());
         end
      end
      if (reserve_o !== exe_plain_lr)
      begin
         value_error("reserve_o", word_t'(exe_plain_lr), word_t'(reserve_o));
      end
      if (exe_acq_lr && reservation_i && to_mem_o.valid)
      begin
         plain_error("LR acquire sent a command while the reservation was held");
      end
      if (reserve_o)
      begin
         reserve_seen = 1'b1;
      end
      // Pipeline advances, the request on req_i is taken
      if (!stall_o && !hold_i)
      begin
         exe_plain_lr = req_i.valid && req_i.is_lr && !req_i.lr_acquire;
         exe_acq_lr = req_i.valid && req_i.is_lr && req_i.lr_acquire;
         if (req_i.valid)
         begin
            void'(send_q.pop_front());
         end
      end
   endtask

   task automatic run_until_idle();
      while (send_q.size() > 0 || op_q.size() > 0 || reply_q.size() > 0 || wb_q.size() > 0)
      begin
         cycle();
      end
      // A few quiet cycles catch stray write-backs
      repeat (4) cycle();
   endtask

   task automatic end_test(string name, int err_before);
      test_num++;
      $display("test %0d %-26s %0d errors", test_num, name, errors - err_before);
   endtask

   task automatic queue_random(int n);
      size_t sz;
      for (int i = 0; i < n; i++)
      begin
         sz = size_t'($unsigned($random(seed)) % 3);
         queue_req(1'($random(seed)), sz, 1'($random(seed)), rand_addr(sz), $random(seed),
                   1'b0, 1'b0);
      end
   endtask

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////

   task automatic test_word_store_load();
      word_t addrs [N_WORD];
      int    e0;
      e0 = errors;
      for (int i = 0; i < N_WORD; i++)
      begin
         addrs[i] = rand_addr(SIZE_WORD);
         queue_req(1'b1, SIZE_WORD, 1'b0, addrs[i], $random(seed), 1'b0, 1'b0);
      end
      for (int i = 0; i < N_WORD; i++)
      begin
         queue_req(1'b0, SIZE_WORD, 1'b0, addrs[i], '0, 1'b0, 1'b0);
      end
      run_until_idle();
      end_test("word store and load", e0);
   endtask

   // Narrow stores, then word loads that show the merge
   task automatic test_narrow_merge();
      word_t addrs [N_MERGE];
      size_t sz;
      int    e0;
      e0 = errors;
      for (int i = 0; i < N_MERGE; i++)
      begin
         sz = ($random(seed) & 1) ? SIZE_HALF : SIZE_BYTE;
         addrs[i] = rand_addr(sz);
         queue_req(1'b1, sz, 1'b0, addrs[i], $random(seed), 1'b0, 1'b0);
      end
      for (int i = 0; i < N_MERGE; i++)
      begin
         queue_req(1'b0, SIZE_WORD, 1'b0, {addrs[i][31:2], 2'b00}, '0, 1'b0, 1'b0);
      end
      run_until_idle();
      end_test("byte and half stores", e0);
   endtask

   // Halves only at even offsets
   task automatic test_load_offsets();
      int e0;
      e0 = errors;
      for (int p = 0; p < N_OFFS; p++)
      begin
         for (int lo = 0; lo < 4; lo++)
         begin
            for (int u = 0; u < 2; u++)
            begin
               queue_req(1'b0, SIZE_BYTE, 1'(u), rand_addr(SIZE_WORD) | word_t'(lo), '0,
                         1'b0, 1'b0);
            end
         end
         for (int lo = 0; lo < 4; lo += 2)
         begin
            for (int u = 0; u < 2; u++)
            begin
               queue_req(1'b0, SIZE_HALF, 1'(u), rand_addr(SIZE_WORD) | word_t'(lo), '0,
                         1'b0, 1'b0);
            end
         end
      end
      run_until_idle();
      end_test("narrow load offsets", e0);
   endtask

   task automatic test_random_mix();
      int e0;
      e0 = errors;
      queue_random(N_RAND);
      run_until_idle();
      end_test("random mix", e0);
   endtask

   // Random hold lands around replies and fills the load buffer
   task automatic test_hold();
      int e0;
      e0 = errors;
      hold_mode = 1'b1;
      queue_random(N_HOLD);
      run_until_idle();
      hold_mode = 1'b0;
      end_test("hold around replies", e0);
   endtask

   task automatic test_reservation();
      word_t a;
      int    e0;
      e0 = errors;
      a = rand_addr(SIZE_WORD);
      queue_req(1'b1, SIZE_WORD, 1'b0, a, $random(seed), 1'b0, 1'b0);
      run_until_idle();
      resv_level = 1'b1;
      queue_req(1'b0, SIZE_WORD, 1'b0, a, '0, 1'b1, 1'b1);
      repeat (8) cycle();
      if (op_q.size() == 0)
      begin
         plain_error("LR acquire reached memory while the reservation was held");
      end
      resv_level = 1'b0;
      run_until_idle();
      reserve_seen = 1'b0;
      queue_req(1'b0, SIZE_WORD, 1'b0, a, '0, 1'b1, 1'b0);
      run_until_idle();
      if (!reserve_seen)
      begin
         plain_error("reserve_o never rose for a plain LR");
      end
      end_test("load reservation", e0);
   endtask

   ////////////////////////////////////////
   // Write-back comparison
   ////////////////////////////////////////

   always @(posedge clk)
   begin
      #1;
      if (wb_o.valid)
      begin
         checks++;
         if (wb_q.size() == 0)
         begin
            plain_error("write-back with no load pending");
         end
         else
         begin
            wb_want = wb_q.pop_front();
            if (wb_o.rd !== wb_want.rd)
            begin
               value_error("wb_o.rd", word_t'(wb_want.rd), word_t'(wb_o.rd));
            end
            if (wb_o.data !== wb_want.data)
            begin
               value_error("wb_o.data", wb_want.data, wb_o.data);
            end
         end
      end
   end

   // Watchdog
   initial
   begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("timeout: run went past %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

   initial
   begin
      reset = 1'b1;
      req_i = '0;
      hold_i = 1'b0;
      from_mem_i = '0;
      reservation_i = 1'b0;
      // Fill depends on the word's byte address
      for (int i = 0; i < 16; i++)
      begin
         mem[i] = ((word_t'(i) << 2) * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
         ref_mem[i] = mem[i];
      end
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      if (to_mem_o.valid || to_mem_o.yumi || wb_o.valid || reserve_o || stall_o)
      begin
         plain_error("outputs not low during reset");
      end
      reset = 1'b0;

      test_word_store_load();
      test_narrow_merge();
      test_load_offsets();
      test_random_mix();
      test_hold();
      test_reservation();

      $display("tests %0d, requests %0d, checks %0d, errors %0d, assertion failures %0d",
               test_num, req_count, checks, errors,
               u_vc_mem_stage.u_vc_mem_assertions.fail_count);
      if (errors == 0 && u_vc_mem_stage.u_vc_mem_assertions.fail_count == 0)
      begin
         $display(">>> PASS");
      end
      else
      begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// File: verif/vc_mem_assertions.sv
`timescale 1ns/1ps

module vc_mem_assertions
(
   input logic                  clk,
   input logic                  reset,
   input vc_mem_pkg::mem_cmd_s  cmd_i,
   input vc_mem_pkg::mem_resp_s resp_i,
   input vc_mem_pkg::wb_s       wb_i
);

   // Failure count, read by the testbench at the end of the run
   int fail_count = 0;

   // A command waiting for yumi keeps its contents, hold may withdraw it
   cmd_stable: assert property (
      @(posedge clk) disable iff (reset)
      (cmd_i.valid && !resp_i.yumi) |=>
         (!cmd_i.valid || $stable({cmd_i.wen, cmd_i.mask, cmd_i.addr, cmd_i.write_data})))
   else
   begin
      fail_count++;
      $error("memory command changed before it was accepted");
   end

   // No write-back pulse once reset has been seen
   wb_quiet_in_reset: assert property (
      @(posedge clk) (reset && $past(reset)) |-> !wb_i.valid)
   else
   begin
      fail_count++;
      $error("write-back valid during reset");
   end

   // Every command enables at least one byte
   mask_nonzero: assert property (
      @(posedge clk) disable iff (reset)
      cmd_i.valid |-> (cmd_i.mask != 4'b0000))
   else
   begin
      fail_count++;
      $error("memory command with an empty byte mask");
   end

endmodule

bind vc_mem_stage vc_mem_assertions u_vc_mem_assertions
(
   .clk    (clk),
   .reset  (reset),
   .cmd_i  (to_mem_o),
   .resp_i (from_mem_i),
   .wb_i   (wb_o)
);

// File: src/vc_mem_stage.sv
`timescale 1ns/1ps

module vc_mem_stage
(
   input  logic                  clk,
   input  logic                  reset,
   input  vc_mem_pkg::mem_req_s  req_i,
   input  logic                  hold_i,
   input  vc_mem_pkg::mem_resp_s from_mem_i,
   input  logic                  reservation_i,
   output vc_mem_pkg::mem_cmd_s  to_mem_o,
   output logic                  stall_o,
   output logic                  reserve_o,
   output vc_mem_pkg::wb_s       wb_o
);
   import vc_mem_pkg::*;

   mem_cmd_s  issue_cmd;
   mem_slot_s slot;
   logic      advance;
   logic      load_wait;
   logic      reply_yumi;

   // Execute stage, drives the command side
   mem_issue u_mem_issue
   (
      .clk           (clk),
      .reset         (reset),
      .req_i         (req_i),
      .hold_i        (hold_i),
      .reservation_i (reservation_i),
      .mem_yumi_i    (from_mem_i.yumi),
      .load_wait_i   (load_wait),
      .cmd_o         (issue_cmd),
      .slot_o        (slot),
      .advance_o     (advance),
      .stall_o       (stall_o),
      .reserve_o     (reserve_o)
   );

   // Memory and write-back stages
   load_return u_load_return
   (
      .clk         (clk),
      .reset       (reset),
      .slot_i      (slot),
      .advance_i   (advance),
      .hold_i      (hold_i),
      .resp_i      (from_mem_i),
      .yumi_o      (reply_yumi),
      .load_wait_o (load_wait),
      .wb_o        (wb_o)
   );

   // Reply ack joins the command bundle
   assign to_mem_o = '{
      valid      : issue_cmd.valid,
      wen        : issue_cmd.wen,
      mask       : issue_cmd.mask,
      addr       : issue_cmd.addr,
      write_data : issue_cmd.write_data,
      yumi       : reply_yumi
   };

endmodule

// File: src/load_return.sv
`timescale 1ns/1ps

module load_return
(
   input  logic                  clk,
   input  logic                  reset,
   input  vc_mem_pkg::mem_slot_s slot_i,
   input  logic                  advance_i,
   input  logic                  hold_i,
   input  vc_mem_pkg::mem_resp_s resp_i,
   output logic                  yumi_o,
   output logic                  load_wait_o,
   output vc_mem_pkg::wb_s       wb_o
);
   import vc_mem_pkg::*;

   // Memory stage
   mem_slot_s   slot_r;
   // Reply held while the pipeline is frozen
   logic        buf_valid_r;
   word_t       buf_data_r;
   // Write-back register
   logic        wb_valid_r;
   reg_addr_t   wb_rd_r;
   word_t       wb_data_r;

   logic        reply_take;
   logic        frozen;
   logic        buf_fill;
   logic        wb_load;
   word_t       load_word;
   logic [7:0]  load_byte;
   logic [15:0] load_half;
   word_t       load_val;

   ////////////////////////////////////////
   // Reply handshake
   ////////////////////////////////////////

   // Only the first reply belongs to this slot, later ones wait in memory
   assign reply_take  = slot_r.is_mem & ~buf_valid_r & resp_i.valid;
   assign yumi_o      = reply_take;

   // Stores wait as well so their reply is not taken by the next op
   assign load_wait_o = slot_r.is_mem & ~buf_valid_r & ~resp_i.valid;

   // Core hold, or a stall raised on the issue side
   assign frozen      = hold_i | ~advance_i;
   assign buf_fill    = reply_take & frozen;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         buf_valid_r <= 1'b0;
      end
      else if (advance_i)
      begin
         buf_valid_r <= 1'b0;
      end
      else if (buf_fill)
      begin
         buf_valid_r <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (buf_fill)
      begin
         buf_data_r <= resp_i.read_data;
      end
   end

   ////////////////////////////////////////
   // Load extraction
   ////////////////////////////////////////

   assign load_word = buf_valid_r ? buf_data_r : resp_i.read_data;

   always_comb
   begin
      case (slot_r.addr_lo)
         2'd0:    load_byte = load_word[7:0];
         2'd1:    load_byte = load_word[15:8];
         2'd2:    load_byte = load_word[23:16];
         default: load_byte = load_word[31:24];
      endcase
   end

   // Half-words sit in the low or high lane
   assign load_half = slot_r.addr_lo[1] ? load_word[31:16] : load_word[15:0];

   always_comb
   begin
      case (slot_r.size)
         SIZE_BYTE:
            load_val = slot_r.load_unsigned ? word_t'(load_byte)
                                            : {{24{load_byte[7]}}, load_byte};
         SIZE_HALF:
            load_val = slot_r.load_unsigned ? word_t'(load_half)
                                            : {{16{load_half[15]}}, load_half};
         // Full word passes straight through
         default:
            load_val = load_word;
      endcase
   end

   ////////////////////////////////////////
   // Stage registers
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         slot_r <= '0;
      end
      else if (advance_i)
      begin
         slot_r <= slot_i;
      end
   end

   // Data is present whenever the pipeline advances
   assign wb_load = advance_i & slot_r.is_load;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wb_valid_r <= 1'b0;
      end
      else
      begin
         // One-cycle pulse per load
         wb_valid_r <= wb_load;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wb_load)
      begin
         wb_rd_r   <= slot_r.rd;
         wb_data_r <= load_val;
      end
   end

   assign wb_o = '{valid: wb_valid_r, rd: wb_rd_r, data: wb_data_r};

endmodule

// File: src/mem_issue.sv
`timescale 1ns/1ps

module mem_issue
(
   input  logic                  clk,
   input  logic                  reset,
   input  vc_mem_pkg::mem_req_s  req_i,
   input  logic                  hold_i,
   input  logic                  reservation_i,
   input  logic                  mem_yumi_i,
   input  logic                  load_wait_i,
   output vc_mem_pkg::mem_cmd_s  cmd_o,
   output vc_mem_pkg::mem_slot_s slot_o,
   output logic                  advance_o,
   output logic                  stall_o,
   output logic                  reserve_o
);
   import vc_mem_pkg::*;

   // Stage occupancy and the registered request
   logic       exe_valid_r;
   mem_req_s   exe_r;
   // Command went out while the pipeline was frozen
   logic       exe_sent_r;

   logic       exe_is_mem;
   logic       lr_active;
   logic       lr_wait;
   logic       cmd_valid;
   logic       cmd_taken;
   word_t      addr;
   logic [4:0] lane_shift;
   word_t      store_lane;
   byte_mask_t mask;

   ////////////////////////////////////////
   // Address and store alignment
   ////////////////////////////////////////

   // LR addresses by base alone
   assign addr       = exe_r.is_lr ? exe_r.base : exe_r.base + exe_r.offset;
   // Byte offset turned into a bit shift
   assign lane_shift = {addr[1:0], 3'b000};

   always_comb
   begin
      case (exe_r.size)
         SIZE_BYTE:
         begin
            store_lane = word_t'(exe_r.store_val[7:0]) << lane_shift;
            mask       = 4'b0001 << addr[1:0];
         end
         SIZE_HALF:
         begin
            store_lane = word_t'(exe_r.store_val[15:0]) << lane_shift;
            mask       = 4'b0011 << addr[1:0];
         end
         default:
         begin
            // Full word, already aligned
            store_lane = exe_r.store_val;
            mask       = 4'b1111;
         end
      endcase
   end

   ////////////////////////////////////////
   // Reservation and stall
   ////////////////////////////////////////

   assign exe_is_mem = exe_valid_r & (exe_r.is_load | exe_r.is_store);
   assign lr_active  = exe_valid_r & exe_r.is_lr;

   // Plain LR sets the reservation
   assign reserve_o  = lr_active & ~exe_r.lr_acquire;
   // LR acquire sits until the reservation drops
   assign lr_wait    = lr_active & exe_r.lr_acquire & reservation_i;

   // Send once per request, never under hold or LR wait
   assign cmd_valid  = exe_is_mem & ~exe_sent_r & ~hold_i & ~lr_wait;
   assign cmd_taken  = cmd_valid & mem_yumi_i;

   // Unaccepted command, missing load data, or LR wait
   assign stall_o    = (exe_is_mem & ~(exe_sent_r | cmd_taken)) | load_wait_i | lr_wait;
   assign advance_o  = ~stall_o & ~hold_i;

   assign cmd_o = '{
      valid      : cmd_valid,
      wen        : exe_r.is_store,
      mask       : mask,
      addr       : addr,
      write_data : store_lane,
      yumi       : 1'b0
   };

   assign slot_o = '{
      is_load       : exe_valid_r & exe_r.is_load,
      is_mem        : exe_is_mem,
      size          : exe_r.size,
      load_unsigned : exe_r.load_unsigned,
      addr_lo       : addr[1:0],
      rd            : exe_r.rd
   };

   ////////////////////////////////////////
   // Stage registers
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         exe_valid_r <= 1'b0;
         exe_sent_r  <= 1'b0;
      end
      else if (advance_o)
      begin
         // Empty stage when nothing new arrives
         exe_valid_r <= req_i.valid;
         exe_sent_r  <= 1'b0;
      end
      else if (cmd_taken)
      begin
         exe_sent_r  <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (advance_o && req_i.valid)
      begin
         exe_r <= req_i;
      end
   end

endmodule

// File: src/vc_mem_pkg.sv
package vc_mem_pkg;

   ////////////////////////////////////////
   // Widths
   ////////////////////////////////////////

   localparam int WORD_W     = 32;
   localparam int REG_ADDR_W = 5;
   localparam int MASK_W     = WORD_W / 8;
   localparam int SIZE_W     = 2;

   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [MASK_W-1:0]     byte_mask_t;
   typedef logic [SIZE_W-1:0]     size_t;

   // Access size codes
   localparam size_t SIZE_BYTE = 2'd0;
   localparam size_t SIZE_HALF = 2'd1;
   localparam size_t SIZE_WORD = 2'd2;

   ////////////////////////////////////////
   // Port structs
   ////////////////////////////////////////

   // One load or store from the core
   typedef struct packed {
      logic      valid;
      logic      is_load;
      logic      is_store;
      size_t     size;
      logic      load_unsigned;
      logic      is_lr;
      // Set means wait for the reservation to clear
      logic      lr_acquire;
      word_t     base;
      word_t     offset;
      word_t     store_val;
      reg_addr_t rd;
   } mem_req_s;

   // Command towards data memory, yumi acks the reply
   typedef struct packed {
      logic       valid;
      logic       wen;
      byte_mask_t mask;
      word_t      addr;
      word_t      write_data;
      logic       yumi;
   } mem_cmd_s;

   // Reply from data memory, yumi acks the command
   typedef struct packed {
      logic  yumi;
      logic  valid;
      word_t read_data;
   } mem_resp_s;

   // Execute to memory stage hand-over
   typedef struct packed {
      logic      is_load;
      logic      is_mem;
      size_t     size;
      logic      load_unsigned;
      logic [1:0] addr_lo;
      reg_addr_t rd;
   } mem_slot_s;

   // Register write-back
   typedef struct packed {
      logic      valid;
      reg_addr_t rd;
      word_t     data;
   } wb_s;

endpackage
